// ==== hw/acc_core.sv ====
module acc_core import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              load_done,
    input  logic [DATA_W-1:0] instr,
    output logic [PC_W-1:0]   pc,
    output logic [DATA_W-1:0] acc,
    output logic              done
);

    core_state_e        state;
    logic [DATA_W-1:0]  ir;
    logic               carry_flag;
    logic               zero_flag;
    logic [DATA_W-1:0]  dmem [2**DMEM_AW];
    logic [DATA_W-1:0]  dmem_q;
    logic [DMEM_AW-1:0] dmem_addr;
    logic               dmem_we;
    logic               dmem_rd;
    logic               is_mem_alu;
    logic               is_jump;
    logic               jump_taken;
    logic               arith_op;
    alu_op_e            alu_op;
    logic [DATA_W-1:0]  operand_b;
    logic [DATA_W-1:0]  alu_result;
    logic               alu_carry;
    logic               alu_zero;

    assign is_mem_alu = !ir[7];
    assign is_jump    = (ir[7:4] == OP_JUMP);
    assign dmem_addr  = ir[DMEM_AW-1:0];
    assign dmem_we    = (state == ST_DECODE) && (ir[7:4] == OP_STORE);
    assign dmem_rd    = (state == ST_DECODE) && is_mem_alu;
    assign done       = (state == ST_HALT);

    always_comb begin
        alu_op    = is_mem_alu ? alu_op_e'(ir[6:4]) : alu_op_e'(ir[2:0]);
        operand_b = is_mem_alu ? dmem_q : instr; // Immediate sits at the current pc.
        arith_op  = alu_op inside {ALU_ADD, ALU_SUB, ALU_ADC, ALU_SBB};
        case (ir[1:0])
            2'd0:    jump_taken = 1'b1;
            2'd1:    jump_taken = carry_flag;
            2'd2:    jump_taken = zero_flag;
            default: jump_taken = !zero_flag;
        endcase
    end

    alu i_alu (
        .alu_op    (alu_op),
        .operand_a (acc),
        .operand_b (operand_b),
        .carry_in  (carry_flag),
        .result    (alu_result),
        .carry_out (alu_carry),
        .zero      (alu_zero)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**DMEM_AW; i++) begin
                dmem[i] <= '0;
            end
        end else if (dmem_we) begin
            dmem[dmem_addr] <= acc;
        end
    end

    // Synchronous read, so the operand is ready in execute.
    always_ff @(posedge clk) begin
        if (dmem_rd) begin
            dmem_q <= dmem[dmem_addr];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= ST_IDLE;
            pc         <= '0;
            ir         <= '0;
            acc        <= '0;
            carry_flag <= 1'b0;
            zero_flag  <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load_done) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    ir    <= instr;
                    state <= ST_DECODE;
                end
                ST_DECODE: begin
                    pc <= pc + 1'b1; // Now points at the operand byte or the next opcode.
                    if (is_mem_alu) begin
                        state <= ST_EXEC;
                    end else begin
                        case (ir[7:4])
                            OP_STORE:            state <= ST_FETCH;
                            OP_ALU_IMM, OP_JUMP: state <= ST_EXEC;
                            OP_SYS:              state <= (ir[3:0] == 4'hF) ? ST_HALT : ST_FETCH;
                            default:             state <= ST_HALT;
                        endcase
                    end
                end
                ST_EXEC: begin
                    state <= ST_FETCH;
                    if (is_jump) begin
                        pc <= jump_taken ? instr : pc + 1'b1;
                    end else begin
                        acc       <= alu_result;
                        zero_flag <= alu_zero;
                        if (arith_op) begin
                            carry_flag <= alu_carry;
                        end
                        if (!is_mem_alu) begin
                            pc <= pc + 1'b1; // Step over the immediate.
                        end
                    end
                end
                ST_HALT: begin
                    state <= ST_HALT;
                end
                default: begin
                    state <= ST_HALT;
                end
            endcase
        end
    end

endmodule

// ==== hw/alu.sv ====
module alu import cpu_pkg::*; (
    input  alu_op_e           alu_op,
    input  logic [DATA_W-1:0] operand_a,
    input  logic [DATA_W-1:0] operand_b,
    input  logic              carry_in,
    output logic [DATA_W-1:0] result,
    output logic              carry_out,
    output logic              zero
);

    logic            cin_eff;
    logic [DATA_W:0] sum;
    logic [DATA_W:0] diff;

    // Only ADC and SBB take the incoming carry.
    assign cin_eff = (alu_op == ALU_ADC || alu_op == ALU_SBB) ? carry_in : 1'b0;
    assign sum     = {1'b0, operand_a} + {1'b0, operand_b} + (DATA_W + 1)'(cin_eff);
    assign diff    = {1'b0, operand_a} - {1'b0, operand_b} - (DATA_W + 1)'(cin_eff);

    always_comb begin
        carry_out = 1'b0;
        case (alu_op)
            ALU_ADD, ALU_ADC: begin
                result    = sum[DATA_W-1:0];
                carry_out = sum[DATA_W];
            end
            ALU_SUB, ALU_SBB: begin
                result    = diff[DATA_W-1:0];
                carry_out = diff[DATA_W]; // Borrow.
            end
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_XOR: result = operand_a ^ operand_b;
            default: result = operand_b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    localparam int DATA_W  = 8;
    localparam int PC_W    = 8;
    localparam int DMEM_AW = 4;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_ADC  = 3'd2,
        ALU_SBB  = 3'd3,
        ALU_AND  = 3'd4,
        ALU_OR   = 3'd5,
        ALU_XOR  = 3'd6,
        ALU_PASS = 3'd7
    } alu_op_e;

    // Upper nibbles below 8 are memory-operand ALU instructions.
    typedef enum logic [3:0] {
        OP_STORE   = 4'd8,
        OP_ALU_IMM = 4'd12,
        OP_JUMP    = 4'd13,
        OP_SYS     = 4'd15
    } op_class_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_HALT
    } core_state_e;

    function automatic logic [3:0] ascii_to_nibble(input logic [7:0] ch);
        logic [3:0] nib;
        if (ch >= 8'h30 && ch <= 8'h39) begin
            nib = 4'(ch - 8'h30);
        end else if (ch >= 8'h41 && ch <= 8'h46) begin
            nib = 4'(ch - 8'h37);
        end else if (ch >= 8'h61 && ch <= 8'h66) begin
            nib = 4'(ch - 8'h57);
        end else begin
            nib = 4'h0; // Anything that is not a hex digit reads as zero.
        end
        return nib;
    endfunction

endpackage

// ==== hw/hex_loader.sv ====
module hex_loader import cpu_pkg::*; #(
    parameter int IDLE_TIMEOUT = 50_000_000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] byte_data,
    input  logic              byte_valid,
    output logic              wr_en,
    output logic [PC_W-1:0]   wr_addr,
    output logic [DATA_W-1:0] wr_data,
    output logic              half_byte,
    output logic              load_done
);

    localparam int IDLE_W = $clog2(IDLE_TIMEOUT + 1);
    localparam logic [IDLE_W-1:0] IDLE_LIMIT = IDLE_W'(IDLE_TIMEOUT);

    logic [3:0]        digit;
    logic [3:0]        high_nibble;
    logic [IDLE_W-1:0] idle_cnt;
    logic              accept;

    assign digit  = ascii_to_nibble(byte_data);
    assign accept = byte_valid && !load_done; // The program is frozen once loading ends.

    // The second digit of a pair completes the byte and writes it straight away.
    assign wr_en   = accept && half_byte;
    assign wr_data = {high_nibble, digit};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            half_byte <= 1'b0;
            wr_addr   <= '0;
            idle_cnt  <= '0;
            load_done <= 1'b0;
        end else begin
            if (accept) begin
                half_byte <= !half_byte;
                if (half_byte) begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
            if (byte_valid) begin
                idle_cnt <= '0;
            end else if (idle_cnt == IDLE_LIMIT) begin
                load_done <= 1'b1; // Sticky until reset.
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !half_byte) begin
            high_nibble <= digit;
        end
    end

endmodule

// ==== hw/program_mem.sv ====
module program_mem import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic [PC_W-1:0]   wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic [PC_W-1:0]   pc,
    output logic [DATA_W-1:0] instr
);

    logic [DATA_W-1:0] mem [2**PC_W];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**PC_W; i++) begin
                mem[i] <= '0; // Unloaded bytes decode as memory-operand ADD.
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign instr = mem[pc];

endmodule

// ==== hw/serial_loaded_cpu.sv ====
module serial_loaded_cpu import cpu_pkg::*; #(
    parameter int CLKS_PER_BIT = 10417,
    parameter int IDLE_TIMEOUT = 50_000_000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx,
    output logic [DATA_W-1:0] acc,
    output logic              done,
    output logic              load_done,
    output logic              half_byte
);

    logic [DATA_W-1:0] byte_data;
    logic              byte_valid;
    logic              wr_en;
    logic [PC_W-1:0]   wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [PC_W-1:0]   pc;
    logic [DATA_W-1:0] instr;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    hex_loader #(
        .IDLE_TIMEOUT (IDLE_TIMEOUT)
    ) i_loader (
        .clk        (clk),
        .reset      (reset),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .half_byte  (half_byte),
        .load_done  (load_done)
    );

    program_mem i_prog_mem (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .pc      (pc),
        .instr   (instr)
    );

    acc_core i_core (
        .clk       (clk),
        .reset     (reset),
        .load_done (load_done),
        .instr     (instr),
        .pc        (pc),
        .acc       (acc),
        .done      (done)
    );

endmodule

// ==== hw/uart_rx.sv ====
module uart_rx import cpu_pkg::*; #(
    parameter int CLKS_PER_BIT = 10417
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx,
    output logic [DATA_W-1:0] byte_data,
    output logic              byte_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e         state;
    logic              rx_meta;
    logic              rx_sync;
    logic              rx_prev;
    logic [CNT_W-1:0]  clk_cnt;
    logic [2:0]        bit_idx;
    logic [DATA_W-1:0] shift_reg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1; // The idle line is high.
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= RX_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA; // A glitch is not a start bit.
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        byte_valid <= rx_sync; // Framing error drops the byte.
                        state      <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first, so bits shift in from the top.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == FULL_BIT) begin
            shift_reg <= {rx_sync, shift_reg[DATA_W-1:1]};
        end
    end

    assign byte_data = shift_reg;

endmodule

// ==== project.f ====
hw/cpu_pkg.sv
hw/uart_rx.sv
hw/hex_loader.sv
hw/program_mem.sv
hw/alu.sv
hw/acc_core.sv
hw/serial_loaded_cpu.sv
tests/cpu_properties.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
    --top-module tb_top -o sim_tb_top \
    && ./obj_dir/sim_tb_top > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qF "*** PASSED ***" sim.log && exit 0 || exit 1

// ==== tests/cpu_properties.sv ====
module cpu_properties import cpu_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        done,
    input logic        load_done,
    input logic        wr_en,
    input core_state_e core_state
);
    timeunit 1ns;
    timeprecision 1ps;

    done_sticky: assert property (@(posedge clk) disable iff (reset) done |=> done)
        else $error("done fell without a reset");

    load_done_sticky: assert property (@(posedge clk) disable iff (reset)
        load_done |=> load_done)
        else $error("load_done fell without a reset");

    // The program is frozen once loading has ended.
    no_write_after_load: assert property (@(posedge clk) disable iff (reset)
        load_done |-> !wr_en)
        else $error("program memory written after load_done");

    idle_until_loaded: assert property (@(posedge clk) disable iff (reset)
        (core_state == ST_IDLE && !load_done) |=> (core_state == ST_IDLE))
        else $error("core left idle before load_done");

endmodule

bind serial_loaded_cpu cpu_properties i_properties (
    .clk        (clk),
    .reset      (reset),
    .done       (done),
    .load_done  (load_done),
    .wr_en      (wr_en),
    .core_state (i_core.state)
);

// ==== tests/tb_checker.sv ====
module tb_checker import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] acc,
    input  logic       done,
    input  logic       load_done,
    input  logic       half_byte,
    input  logic       char_sent,
    input  logic       test_end,
    output int         tests_passed,
    output int         tests_failed
);
    timeunit 1ns;
    timeprecision 1ps;

    int         digit_count;
    int         test_errors;
    logic       half_expected;
    logic [7:0] expected;

    function automatic logic [3:0] hex_value(input logic [7:0] ch);
        if (ch >= 8'h30 && ch <= 8'h39) begin
            return 4'(ch - 8'h30);
        end
        if (ch >= 8'h41 && ch <= 8'h46) begin
            return 4'(ch - 8'h41 + 8'd10);
        end
        if (ch >= 8'h61 && ch <= 8'h66) begin
            return 4'(ch - 8'h61 + 8'd10);
        end
        return 4'h0;
    endfunction

    // Returns the carry or borrow in bit 8 above the 8-bit result.
    function automatic logic [8:0] alu_model(input alu_op_e op, input logic [7:0] a,
                                             input logic [7:0] b, input logic cin);
        case (op)
            ALU_ADD: return {1'b0, a} + {1'b0, b};
            ALU_ADC: return {1'b0, a} + {1'b0, b} + {8'd0, cin};
            ALU_SUB: return {1'b0, a} - {1'b0, b};
            ALU_SBB: return {1'b0, a} - {1'b0, b} - {8'd0, cin};
            ALU_AND: return {1'b0, a & b};
            ALU_OR:  return {1'b0, a | b};
            ALU_XOR: return {1'b0, a ^ b};
            default: return {1'b0, b};
        endcase
    endfunction

    function automatic logic [7:0] expected_acc(input string text);
        logic [7:0] prog [256];
        logic [7:0] dmem [16];
        logic [7:0] a;
        logic [7:0] pc;
        logic [7:0] op;
        logic [7:0] arg;
        logic [8:0] res;
        logic [2:0] sel;
        logic       c;
        logic       z;
        logic       taken;
        logic       halted;
        int         steps;
        for (int i = 0; i < 256; i++) begin
            prog[i] = 8'h00;
            dmem[i % 16] = 8'h00;
        end
        for (int i = 0; i + 1 < text.len(); i += 2) begin
            prog[i / 2] = {hex_value(text[i]), hex_value(text[i + 1])}; // A lone last digit is dropped.
        end
        a = 8'h00;
        pc = 8'h00;
        c = 1'b0;
        z = 1'b1;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 10000) begin
            op = prog[pc];
            pc = pc + 8'd1;
            arg = prog[pc];
            steps++;
            if (op[7:4] == 4'h8) begin
                dmem[op[3:0]] = a;
            end else if (op[7:4] == 4'hD) begin
                pc = pc + 8'd1;
                case (op[1:0])
                    2'd0:    taken = 1'b1;
                    2'd1:    taken = c;
                    2'd2:    taken = z;
                    default: taken = !z;
                endcase
                if (taken) begin
                    pc = arg;
                end
            end else if (op[7:4] == 4'hF && op[3:0] != 4'hF) begin
                // No-op.
            end else if (!op[7] || op[7:4] == 4'hC) begin
                sel = op[7] ? op[2:0] : op[6:4];
                if (op[7]) begin
                    pc = pc + 8'd1;
                end else begin
                    arg = dmem[op[3:0]];
                end
                res = alu_model(alu_op_e'(sel), a, arg, c);
                a = res[7:0];
                z = (a == 8'h00);
                if (alu_op_e'(sel) inside {ALU_ADD, ALU_SUB, ALU_ADC, ALU_SBB}) begin
                    c = res[8];
                end
            end else begin
                halted = 1'b1;
            end
        end
        return a;
    endfunction

    initial begin
        tests_passed = 0;
        tests_failed = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            digit_count = 0;
            test_errors = 0;
        end else begin
            if (char_sent) begin
                digit_count = digit_count + 1;
                half_expected = 1'(digit_count % 2); // Odd count leaves a digit waiting.
                if (half_byte !== half_expected) begin
                    $display("error %s half_byte expected %b actual %b", tb_top.test_name,
                             half_expected, half_byte);
                    test_errors++;
                end
                if (load_done !== 1'b0) begin
                    $display("error %s load_done expected 0 actual %b", tb_top.test_name,
                             load_done);
                    test_errors++;
                end
            end
            if (test_end) begin
                expected = expected_acc(tb_top.test_text);
                if (done !== 1'b1) begin
                    $display("error %s done expected 1 actual %b", tb_top.test_name, done);
                    test_errors++;
                end
                if (load_done !== 1'b1) begin
                    $display("error %s load_done expected 1 actual %b", tb_top.test_name,
                             load_done);
                    test_errors++;
                end
                if (acc !== expected) begin
                    $display("error %s expected 0x%02h actual 0x%02h", tb_top.test_name,
                             expected, acc);
                    test_errors++;
                end
                if (test_errors == 0) begin
                    $display("test %s passed, acc 0x%02h", tb_top.test_name, acc);
                    tests_passed++;
                end else begin
                    $display("test %s failed with %0d errors", tb_top.test_name, test_errors);
                    tests_failed++;
                end
            end
        end
    end

endmodule

// ==== tests/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int BIT_CLKS   = 16;
    localparam int IDLE_CLKS  = 400;
    localparam int NUM_TESTS  = 5;

    logic       clk = 1'b0;
    logic       reset;
    logic       rx;
    logic [7:0] acc;
    logic       done;
    logic       load_done;
    logic       half_byte;
    logic       char_sent;
    logic       test_end;
    int         tests_passed;
    int         tests_failed;
    string      test_name;
    string      test_text;

    string names [NUM_TESTS] = '{
        "imm_alu",
        "store_mem_alu",
        "carry_chain",
        "cond_jumps",
        "loader_details"
    };

    string texts [NUM_TESTS] = '{
        "C75AC033C6FFC4F0C50CFF",
        "C71180C72581C7078270011203FF",
        "C7F0C020C20585C710C120C30125FF",
        "C705C101D302D20AC7EEC540C0F0D112C799C40FD318C501C002D01EC777FF",
        "c7a5c0x3f0e17" // The E1 byte halts and the trailing 7 is never written.
    };

    always #(CLK_PERIOD / 2) clk = ~clk;

    serial_loaded_cpu #(
        .CLKS_PER_BIT (BIT_CLKS),
        .IDLE_TIMEOUT (IDLE_CLKS)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .acc       (acc),
        .done      (done),
        .load_done (load_done),
        .half_byte (half_byte)
    );

    tb_checker i_checker (
        .clk          (clk),
        .reset        (reset),
        .acc          (acc),
        .done         (done),
        .load_done    (load_done),
        .half_byte    (half_byte),
        .char_sent    (char_sent),
        .test_end     (test_end),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    task automatic drive_bit(input logic value);
        rx = value;
        repeat (BIT_CLKS) @(posedge clk);
        #1;
    endtask

    task automatic send_char(input logic [7:0] ch);
        int idle_bits;
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(ch[i]);
        end
        drive_bit(1'b1);
        char_sent = 1'b1; // The byte has been taken by now.
        @(posedge clk);
        #1;
        char_sent = 1'b0;
        idle_bits = $urandom_range(5, 2);
        repeat (idle_bits) drive_bit(1'b1);
    endtask

    task automatic run_test(input int idx);
        test_name = names[idx];
        test_text = texts[idx];
        reset = 1'b1;
        rx = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < test_text.len(); i++) begin
            send_char(test_text[i]);
        end
        do begin
            @(posedge clk);
            #1;
        end while (!done);
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        rx = 1'b1;
        char_sent = 1'b0;
        test_end = 1'b0;
        void'($urandom(32'h2c3));
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        repeat (2) @(posedge clk);
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed == NUM_TESTS) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Budget per test covers the longest text, the idle timeout and the program run.
    initial begin
        int max_len;
        int limit;
        max_len = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (texts[t].len() > max_len) begin
                max_len = texts[t].len();
            end
        end
        limit = NUM_TESTS * (max_len * 12 * BIT_CLKS + IDLE_CLKS + 2000);
        repeat (limit) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
